// ==== rtl/board_status_pkg.sv ====
// register map, privilege enum, seven-segment glyph tables and scan/led timing constants
`default_nettype none

package board_status_pkg;

    localparam int WB_ADDR_W = 3;   // word address
    localparam int DATA_W    = 32;

    localparam logic [WB_ADDR_W-1:0] REG_CTRL = 3'd0; // bit0 ready, bit1 loading
    localparam logic [WB_ADDR_W-1:0] REG_PRIV = 3'd1;
    localparam logic [WB_ADDR_W-1:0] REG_PC   = 3'd2;
    localparam logic [WB_ADDR_W-1:0] REG_IR   = 3'd3;
    localparam logic [WB_ADDR_W-1:0] REG_HIST = 3'd4; // read only

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    // segment bits {dp,a,b,c,d,e,f,g}, active high
    localparam logic [7:0] SEG_HEX [16] = '{
        8'b0111_1110, 8'b0011_0000, 8'b0110_1101, 8'b0111_1001,  // 0 1 2 3
        8'b0011_0011, 8'b0101_1011, 8'b0101_1111, 8'b0111_0000,  // 4 5 6 7
        8'b0111_1111, 8'b0111_1011, 8'b0111_0111, 8'b0001_1111,  // 8 9 A b
        8'b0100_1110, 8'b0011_1101, 8'b0100_1111, 8'b0100_0111   // C d E F
    };

    // "ArchProc" read from digit 7 down to digit 0
    localparam logic [7:0] SEG_IDLE [8] = '{
        8'b0000_1101, 8'b0001_1101, 8'b0000_0101, 8'b0110_0111,  // c o r P
        8'b0001_0111, 8'b0000_1101, 8'b0000_0101, 8'b0111_0111   // h c r A
    };

    // blank lead-in, then "Loading" and two dots
    localparam logic [7:0] SEG_LOAD [16] = '{
        8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
        8'b0000_1110, 8'b0001_1101, 8'b0111_1101, 8'b0011_1101,  // L o a d
        8'b0001_0000, 8'b0001_0101, 8'b1111_1011,                // i n g.
        8'b1000_0000, 8'b1000_0000
    };

    localparam int SCAN_DIV_DEFAULT = 16000; // cycles per digit at 8 MHz
    localparam int SCROLL_TICKS     = 64;    // scan ticks per scroll step
    localparam int BLINK_W          = 4;     // colour shows 1 cycle in 16
    localparam int PWM_W            = 12;    // breathing ramp

endpackage

`default_nettype wire

// ==== rtl/disp_cfg_if.sv ====
// display configuration interface between the register block and the display units
`timescale 1ns/1ns
`default_nettype none

interface disp_cfg_if;
    import board_status_pkg::*;

    logic              ready;
    logic              loading;
    priv_e             priv;
    logic [DATA_W-1:0] value;   // selected display word

    // driven by the register block
    modport src (
        output ready, loading, priv, value
    );

    // seven-segment scanner and rgb led
    modport dst (
        input ready, loading, priv, value
    );

endinterface

`default_nettype wire

// ==== rtl/status_regs.sv ====
// wishbone classic status registers, keyboard/mouse byte history and button display select
`timescale 1ns/1ns
`default_nettype none

module status_regs (
    input  wire                                 CORE_CLK,
    input  wire                                 CORE_RST_X,
    input  wire                                 i_wb_cyc,
    input  wire                                 i_wb_stb,
    input  wire                                 i_wb_we,
    input  wire [board_status_pkg::WB_ADDR_W-1:0] i_wb_adr,
    input  wire [board_status_pkg::DATA_W-1:0]  i_wb_dat,
    output logic [board_status_pkg::DATA_W-1:0] o_wb_dat,
    output logic                                o_wb_ack,
    input  wire                                 i_btn_u,
    input  wire                                 i_btn_d,
    input  wire                                 i_btn_l,
    input  wire                                 i_btn_r,
    input  wire                                 i_btn_c,
    input  wire                                 i_kbd_we,
    input  wire  [7:0]                          i_kbd_data,
    input  wire                                 i_mouse_we,
    input  wire  [7:0]                          i_mouse_data,
    disp_cfg_if.src                             cfg
);
    import board_status_pkg::*;

    logic              wb_req;
    logic [DATA_W-1:0] rdata;
    logic              ctrl_ready;
    logic              ctrl_loading;
    priv_e             priv_q;
    logic [DATA_W-1:0] pc_q;
    logic [DATA_W-1:0] ir_q;
    logic [DATA_W-1:0] hist_q;
    logic [DATA_W-1:0] value_q;

    // new request only, so ack drops for a cycle between accesses
    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    always_comb begin
        case (i_wb_adr)
            REG_CTRL: rdata = {30'd0, ctrl_loading, ctrl_ready};
            REG_PRIV: rdata = {30'd0, priv_q};
            REG_PC:   rdata = pc_q;
            REG_IR:   rdata = ir_q;
            REG_HIST: rdata = hist_q;
            default:  rdata = '0;   // unmapped
        endcase
    end

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_wb_ack     <= 1'b0;
            ctrl_ready   <= 1'b0;
            ctrl_loading <= 1'b0;
            priv_q       <= PRIV_U;
        end else begin
            o_wb_ack <= wb_req;
            if (wb_req && i_wb_we) begin
                case (i_wb_adr)
                    REG_CTRL: begin
                        ctrl_ready   <= i_wb_dat[0];
                        ctrl_loading <= i_wb_dat[1];
                    end
                    REG_PRIV: priv_q <= priv_e'(i_wb_dat[1:0]);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (wb_req && i_wb_we && i_wb_adr == REG_PC) pc_q <= i_wb_dat;
        if (wb_req && i_wb_we && i_wb_adr == REG_IR) ir_q <= i_wb_dat;
        if (wb_req && !i_wb_we) o_wb_dat <= rdata;  // held while ack is high
    end

    // keyboard lane in the low half, mouse lane in the high half
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            hist_q <= '0;
        end else begin
            if (i_kbd_we) hist_q[15:0] <= {hist_q[7:0], i_kbd_data};
            if (i_mouse_we) hist_q[31:16] <= {hist_q[23:16], i_mouse_data};
        end
    end

    always_ff @(posedge CORE_CLK) begin
        if (i_btn_u || i_btn_d || i_btn_c) value_q <= '0;
        else if (i_btn_l)                  value_q <= pc_q;
        else if (i_btn_r)                  value_q <= ir_q;
        else                               value_q <= hist_q;
    end

    assign cfg.ready   = ctrl_ready;
    assign cfg.loading = ctrl_loading;
    assign cfg.priv    = priv_q;
    assign cfg.value   = value_q;

    a_ack_in_cycle: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

    a_ack_single: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

// ==== rtl/seg7_scan.sv ====
// eight-digit seven-segment scanner with hex, idle banner and scrolling loading banner
`timescale 1ns/1ns
`default_nettype none

module seg7_scan #(
    parameter int SCAN_DIV = board_status_pkg::SCAN_DIV_DEFAULT
) (
    input  wire        CORE_CLK,
    input  wire        CORE_RST_X,
    disp_cfg_if.dst    cfg,
    output logic [7:0] o_seg,   // active low cathodes
    output logic [7:0] o_an     // active low anodes
);
    import board_status_pkg::*;

    typedef enum logic [1:0] {
        MODE_HEX,
        MODE_IDLE,
        MODE_LOAD
    } mode_e;

    logic [$clog2(SCAN_DIV)-1:0]     div_cnt;
    logic                            tick;
    logic [2:0]                      digit;      // next digit to light
    logic [2:0]                      cur_digit;  // digit behind o_an
    logic [3:0]                      scroll;
    logic [$clog2(SCROLL_TICKS)-1:0] scroll_cnt;
    mode_e                           mode;
    logic [3:0]                      nibble;
    logic [3:0]                      load_idx;
    logic [7:0]                      glyph;

    assign tick = (div_cnt == $bits(div_cnt)'(SCAN_DIV - 1));

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            div_cnt   <= '0;
            digit     <= 3'd0;
            cur_digit <= 3'd0;
            o_an      <= 8'hff;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                o_an      <= ~(8'd1 << digit);
                cur_digit <= digit;
                digit     <= digit + 3'd1;   // wraps 7 -> 0
            end
        end
    end

    // scroll position, parked at 0 whenever not loading
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X || !cfg.loading) begin
            scroll     <= 4'd0;
            scroll_cnt <= '0;
        end else if (tick) begin
            if (scroll_cnt == $bits(scroll_cnt)'(SCROLL_TICKS - 1)) begin
                scroll_cnt <= '0;
                scroll     <= scroll + 4'd1;
            end else begin
                scroll_cnt <= scroll_cnt + 1'b1;
            end
        end
    end

    // loading wins over not-ready
    always_comb begin
        if (cfg.loading)     mode = MODE_LOAD;
        else if (!cfg.ready) mode = MODE_IDLE;
        else                 mode = MODE_HEX;
    end

    assign nibble   = cfg.value[{cur_digit, 2'b00} +: 4];
    assign load_idx = scroll + 4'd7 - {1'b0, cur_digit};   // mod 16

    always_comb begin
        case (mode)
            MODE_LOAD: glyph = SEG_LOAD[load_idx];
            MODE_IDLE: glyph = SEG_IDLE[cur_digit];
            default:   glyph = SEG_HEX[nibble];
        endcase
    end

    // pattern lands one cycle after its anode
    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            o_seg <= 8'hff;
        end else if (o_an == 8'hff) begin
            o_seg <= 8'hff;          // nothing lit yet
        end else begin
            o_seg <= ~glyph;
        end
    end

    a_an_onehot0: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        $onehot0(~o_an));

endmodule

`default_nettype wire

// ==== rtl/rgb_priv_led.sv ====
// rgb led with breathing pwm while loading and a privilege colour blink when ready
`timescale 1ns/1ns
`default_nettype none

module rgb_priv_led (
    input  wire        CORE_CLK,
    input  wire        CORE_RST_X,
    disp_cfg_if.dst    cfg,
    output logic [2:0] o_rgb    // {B,G,R}
);
    import board_status_pkg::*;

    logic [PWM_W-1:0]   ramp;
    logic [PWM_W:0]     acc_b;
    logic [PWM_W:0]     acc_g;
    logic [PWM_W:0]     acc_r;
    logic [2:0]         breathe;
    logic [BLINK_W-1:0] blink;

    // msb of the accumulator flips the duty direction, so brightness rises and falls
    function automatic logic pwm_bit(input logic [PWM_W:0] acc, input logic [PWM_W-1:0] pos);
        pwm_bit = acc[PWM_W] ? (acc[PWM_W-1:0] < pos) : (acc[PWM_W-1:0] >= pos);
    endfunction

    always_ff @(posedge CORE_CLK) begin
        if (!CORE_RST_X) begin
            ramp    <= '0;
            acc_b   <= '0;
            acc_g   <= (PWM_W+1)'(64);   // phase offsets so colours drift apart
            acc_r   <= (PWM_W+1)'(512);
            breathe <= 3'b000;
            blink   <= '0;
        end else begin
            ramp  <= ramp + 1'b1;
            blink <= blink + 1'b1;
            if (ramp == '0) begin        // one step per ramp period
                acc_b <= acc_b + (PWM_W+1)'(2);
                acc_g <= acc_g + (PWM_W+1)'(3);
                acc_r <= acc_r + (PWM_W+1)'(5);
            end
            breathe <= {pwm_bit(acc_b, ramp), pwm_bit(acc_g, ramp), pwm_bit(acc_r, ramp)};
        end
    end

    always_comb begin
        if (cfg.loading) begin
            o_rgb = breathe;
        end else if (!cfg.ready || blink != '0) begin
            o_rgb = 3'b000;
        end else begin
            case (cfg.priv)
                PRIV_U:  o_rgb = 3'b100;  // blue
                PRIV_S:  o_rgb = 3'b010;  // green
                PRIV_M:  o_rgb = 3'b001;  // red
                default: o_rgb = 3'b000;
            endcase
        end
    end

    a_single_colour: assert property (@(posedge CORE_CLK) disable iff (!CORE_RST_X)
        (cfg.ready && !cfg.loading) |-> $onehot0(o_rgb));

endmodule

`default_nettype wire

// ==== rtl/board_status_top.sv ====
// board status front panel top with wishbone register block, seven-segment scanner and rgb led
`timescale 1ns/1ns
`default_nettype none

module board_status_top #(
    parameter int SCAN_DIV = board_status_pkg::SCAN_DIV_DEFAULT
) (
    input  wire                                   CORE_CLK,
    input  wire                                   CORE_RST_X,
    input  wire                                   i_wb_cyc,
    input  wire                                   i_wb_stb,
    input  wire                                   i_wb_we,
    input  wire  [board_status_pkg::WB_ADDR_W-1:0] i_wb_adr,
    input  wire  [board_status_pkg::DATA_W-1:0]   i_wb_dat,
    output wire  [board_status_pkg::DATA_W-1:0]   o_wb_dat,
    output wire                                   o_wb_ack,
    input  wire                                   i_btn_u,
    input  wire                                   i_btn_d,
    input  wire                                   i_btn_l,
    input  wire                                   i_btn_r,
    input  wire                                   i_btn_c,
    input  wire                                   i_kbd_we,
    input  wire  [7:0]                            i_kbd_data,
    input  wire                                   i_mouse_we,
    input  wire  [7:0]                            i_mouse_data,
    output wire  [7:0]                            o_seg,
    output wire  [7:0]                            o_an,
    output wire  [2:0]                            o_rgb      // {B,G,R}
);

    disp_cfg_if u_cfg ();

    status_regs u_regs (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .i_btn_u      (i_btn_u),
        .i_btn_d      (i_btn_d),
        .i_btn_l      (i_btn_l),
        .i_btn_r      (i_btn_r),
        .i_btn_c      (i_btn_c),
        .i_kbd_we     (i_kbd_we),
        .i_kbd_data   (i_kbd_data),
        .i_mouse_we   (i_mouse_we),
        .i_mouse_data (i_mouse_data),
        .cfg          (u_cfg.src)
    );

    seg7_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seg (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .cfg        (u_cfg.dst),
        .o_seg      (o_seg),
        .o_an       (o_an)
    );

    rgb_priv_led u_rgb (
        .CORE_CLK   (CORE_CLK),
        .CORE_RST_X (CORE_RST_X),
        .cfg        (u_cfg.dst),
        .o_rgb      (o_rgb)
    );

endmodule

`default_nettype wire

// ==== tb/tb_util.svh ====
// galois lfsr, value check task and reference models for glyphs, led colours and byte history
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

logic [31:0] lfsr_q = 32'h4a48_cbbf;

// one step per bit taken, taps of x^32+x^22+x^2+x+1
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r      = {r[30:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
        fail_stop({"wrong value on ", name});
    end
endtask

// pattern on the pins for digit d, scroll still at its start
function automatic logic [7:0] exp_seg(input logic loading, input logic ready,
                                       input logic [31:0] value, input logic [2:0] d);
    logic [7:0] g;
    if (loading)
        g = SEG_LOAD[4'd7 - {1'b0, d}];
    else if (!ready)
        g = SEG_IDLE[d];
    else
        g = SEG_HEX[4'(value >> {d, 2'b00})];
    return ~g;   // pins are active low
endfunction

function automatic logic [2:0] exp_colour(input logic [1:0] p);
    case (p)
        2'd0:    return 3'b100;   // user, blue
        2'd1:    return 3'b010;   // supervisor, green
        2'd3:    return 3'b001;   // machine, red
        default: return 3'b000;
    endcase
endfunction

// keyboard lane low, mouse lane high, newest byte at the bottom of each lane
function automatic logic [31:0] hist_shift(input logic [31:0] h, input logic kw,
                                           input logic [7:0] kd, input logic mw,
                                           input logic [7:0] md);
    logic [31:0] n;
    n = h;
    if (kw) n[15:0] = {h[7:0], kd};
    if (mw) n[31:16] = {h[23:16], md};
    return n;
endfunction

`endif

// ==== tb/tb_board_status.sv ====
// testbench for the board status top with wishbone driver, display and led checks, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_board_status;
    import board_status_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int SCAN_DIV     = 8;
    localparam int WB_CYCLES    = 5;     // worst case per access
    localparam int N_WB         = 18;
    localparam int ROUND_CYCLES = 12 * SCAN_DIV;
    localparam int N_ROUNDS     = 6;
    localparam int TEST_CYCLES  = 8 + N_WB * WB_CYCLES + N_ROUNDS * ROUND_CYCLES + 3 * 64 + 16;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 3 / 2;

    logic                 CORE_CLK;
    logic                 CORE_RST_X   = 1'b0;
    logic                 wb_cyc       = 1'b0;
    logic                 wb_stb       = 1'b0;
    logic                 wb_we        = 1'b0;
    logic [WB_ADDR_W-1:0] wb_adr       = '0;
    logic [DATA_W-1:0]    wb_dat       = '0;
    logic                 btn_u        = 1'b0;
    logic                 btn_d        = 1'b0;
    logic                 btn_l        = 1'b0;
    logic                 btn_r        = 1'b0;
    logic                 btn_c        = 1'b0;
    logic                 kbd_we       = 1'b0;
    logic [7:0]           kbd_data     = '0;
    logic                 mouse_we     = 1'b0;
    logic [7:0]           mouse_data   = '0;
    wire  [DATA_W-1:0]    o_wb_dat;
    wire                  o_wb_ack;
    wire  [7:0]           o_seg;
    wire  [7:0]           o_an;
    wire  [2:0]           o_rgb;

    // expected display state owned by the stimulus
    logic                 m_ready      = 1'b0;
    logic                 m_loading    = 1'b0;
    logic [31:0]          m_value      = '0;
    logic                 seg_chk_en   = 1'b0;
    int                   seg_checked  = 0;
    int                   round_start  = 0;   // seg_checked when the round began
    int                   since_change = 3;
    logic [7:0]           an_last      = 8'hff;
    logic [2:0]           dig;
    logic [2:0]           dig_prev     = 3'd0;
    logic [2:0]           dig_next;

    `include "tb_util.svh"

    board_status_top #(
        .SCAN_DIV (SCAN_DIV)
    ) u_dut (
        .CORE_CLK     (CORE_CLK),
        .CORE_RST_X   (CORE_RST_X),
        .i_wb_cyc     (wb_cyc),
        .i_wb_stb     (wb_stb),
        .i_wb_we      (wb_we),
        .i_wb_adr     (wb_adr),
        .i_wb_dat     (wb_dat),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .i_btn_u      (btn_u),
        .i_btn_d      (btn_d),
        .i_btn_l      (btn_l),
        .i_btn_r      (btn_r),
        .i_btn_c      (btn_c),
        .i_kbd_we     (kbd_we),
        .i_kbd_data   (kbd_data),
        .i_mouse_we   (mouse_we),
        .i_mouse_data (mouse_data),
        .o_seg        (o_seg),
        .o_an         (o_an),
        .o_rgb        (o_rgb)
    );

    initial begin
        CORE_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CORE_CLK = ~CORE_CLK;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // one classic cycle with ack expected on the second edge and for one cycle only
    task automatic wb_access(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge CORE_CLK);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_dat <= wdat;
        do begin
            @(negedge CORE_CLK);
            waited++;
            if (waited > WB_CYCLES) fail_stop("no Wishbone ack within the expected cycles");
        end while (!o_wb_ack);
        check_eq("wb_ack_latency", 32'(waited), 32'd2);
        rdat = o_wb_dat;
        @(posedge CORE_CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge CORE_CLK);
        check_eq("o_wb_ack", 32'(o_wb_ack), 32'd0);
    endtask

    // lets the comparator see eight digits in a row
    task automatic scan_round();
        int waited;
        waited = 0;
        @(posedge CORE_CLK);
        round_start = seg_checked;
        seg_chk_en  = 1'b1;
        while (seg_checked - round_start < 8) begin
            @(posedge CORE_CLK);
            waited++;
            if (waited > ROUND_CYCLES) fail_stop("scan round did not complete in time");
        end
        seg_chk_en = 1'b0;
    endtask

    task automatic show_button(input logic [4:0] btns, input logic [31:0] expv);
        @(posedge CORE_CLK);
        {btn_u, btn_d, btn_l, btn_r, btn_c} <= btns;
        m_value = expv;
        repeat (2) @(posedge CORE_CLK);   // registered select path
        scan_round();
    endtask

    task automatic rgb_window(input logic [1:0] p);
        logic [31:0] rd;
        int          hits;
        hits = 0;
        wb_access(1'b1, REG_PRIV, {30'd0, p}, rd);
        repeat (64) begin
            @(negedge CORE_CLK);
            if (o_rgb != 3'b000) begin
                check_eq("o_rgb", 32'(o_rgb), 32'(exp_colour(p)));
                hits++;
            end
        end
        check_eq("rgb_blink_hits", 32'(hits), 32'd4);
    endtask

    // o_seg checked two cycles after each anode change
    always @(negedge CORE_CLK) begin
        if (o_an != an_last) begin
            an_last      = o_an;
            since_change = 0;
        end else if (since_change < 3) begin
            since_change++;
        end
        if (seg_chk_en && since_change == 2) begin
            dig = 3'd0;
            for (int i = 0; i < 8; i++)
                if (!an_last[i]) dig = 3'(i);
            check_eq("o_an_low_bits", 32'($countones(~an_last)), 32'd1);
            dig_next = dig_prev + 3'd1;
            if (seg_checked != round_start) check_eq("scan_digit", 32'(dig), 32'(dig_next));
            check_eq("o_seg", 32'(o_seg), 32'(exp_seg(m_loading, m_ready, m_value, dig)));
            dig_prev = dig;
            seg_checked++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_stop("watchdog expired, the test run hung");
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] pc_val;
        logic [31:0] ir_val;
        logic [31:0] hist_exp;
        logic [1:0]  pv;
        logic        kw;
        logic        mw;
        logic [7:0]  kd;
        logic [7:0]  md;
        hist_exp = '0;
        repeat (4) @(posedge CORE_CLK);
        CORE_RST_X <= 1'b1;
        @(negedge CORE_CLK);
        check_eq("o_an", 32'(o_an), 32'hff);
        check_eq("o_seg", 32'(o_seg), 32'hff);
        check_eq("o_rgb", 32'(o_rgb), 32'd0);
        check_eq("o_wb_ack", 32'(o_wb_ack), 32'd0);

        // register access
        wb_access(1'b0, REG_CTRL, '0, rd);
        check_eq("ctrl", rd, 32'd0);
        wb_access(1'b0, REG_HIST, '0, rd);
        check_eq("hist", rd, 32'd0);
        pv = 2'(rand_bits(2));
        if (pv == 2'd2) pv = 2'd3;            // no encoding 2
        pc_val = rand_bits(32);
        ir_val = rand_bits(32);
        wb_access(1'b1, REG_PRIV, {30'd0, pv}, rd);
        wb_access(1'b1, REG_PC, pc_val, rd);
        wb_access(1'b1, REG_IR, ir_val, rd);
        wb_access(1'b1, REG_HIST, rand_bits(32), rd);   // read only
        wb_access(1'b0, REG_PRIV, '0, rd);
        check_eq("priv", rd, {30'd0, pv});
        wb_access(1'b0, REG_PC, '0, rd);
        check_eq("pc", rd, pc_val);
        wb_access(1'b0, REG_IR, '0, rd);
        check_eq("ir", rd, ir_val);
        wb_access(1'b0, REG_HIST, '0, rd);
        check_eq("hist", rd, hist_exp);
        wb_access(1'b0, 3'd5, '0, rd);
        check_eq("unmapped", rd, 32'd0);

        scan_round();                          // idle banner

        wb_access(1'b1, REG_CTRL, 32'd1, rd);
        m_ready = 1'b1;
        show_button(5'b00100, pc_val);         // left
        show_button(5'b00010, ir_val);         // right
        show_button(5'b00001, 32'd0);          // center

        // keyboard and mouse bytes into the history
        repeat (8) begin
            @(posedge CORE_CLK);
            kw = rand_bits(1) != 0;
            kd = 8'(rand_bits(8));
            mw = rand_bits(1) != 0;
            md = 8'(rand_bits(8));
            kbd_we     <= kw;
            kbd_data   <= kd;
            mouse_we   <= mw;
            mouse_data <= md;
            hist_exp = hist_shift(hist_exp, kw, kd, mw, md);
        end
        @(posedge CORE_CLK);
        kbd_we   <= 1'b0;
        mouse_we <= 1'b0;
        wb_access(1'b0, REG_HIST, '0, rd);
        check_eq("hist", rd, hist_exp);
        show_button(5'b00000, hist_exp);

        wb_access(1'b1, REG_CTRL, 32'd3, rd);  // ready and loading
        m_loading = 1'b1;
        scan_round();
        wb_access(1'b1, REG_CTRL, 32'd1, rd);
        m_loading = 1'b0;

        rgb_window(PRIV_U);
        rgb_window(PRIV_S);
        rgb_window(PRIV_M);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+tb
rtl/board_status_pkg.sv
rtl/disp_cfg_if.sv
rtl/status_regs.sv
rtl/seg7_scan.sv
rtl/rgb_priv_led.sv
rtl/board_status_top.sv
tb/tb_board_status.sv

// ==== run.sh ====
#!/bin/sh
# build and run the board status testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_board_status -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
